// ==== Makefile ====
# Verilator build and run for the pin multiplexer testbench
TOP       ?= tb_pinmux
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
OBJ_DIR   ?= obj_dir

SRCS := $(shell grep -v '^+' vlog.f)
HDRS := $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when the file list, a source or a header changes
$(BIN): vlog.f $(SRCS) $(HDRS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f vlog.f

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/pad_drive_sel.sv ====
// Drive half of the pin multiplexer, purely combinational.
// pad_oen_o is active low. A pad not driven outputs 0.
// Priority per pad: strap control, peripherals, WS281x type, GPIO direction.
`timescale 1ns/1ps
`default_nettype none

module pad_drive_sel (
  input  logic                  cfg_strap_pad_ctrl_i,
  input  pinmux_pkg::gpio_t     cfg_gpio_dir_sel_i,
  input  pinmux_pkg::gpio_t     cfg_gpio_out_type_i,
  input  pinmux_pkg::pwm_t      pwm_enb_i,
  input  pinmux_pkg::intr_t     int_enb_i,
  input  pinmux_pkg::uart_t     uart_enb_i,
  input  logic                  spim_enb_i,
  input  pinmux_pkg::cs_t       cs_enb_i,
  input  pinmux_pkg::gpio_t     pad_gpio_out_i,
  input  pinmux_pkg::pwm_t      pwm_wfm_i,
  input  pinmux_pkg::ws_t       ws_txd_i,
  input  pinmux_pkg::uart_t     uart_txd_i,
  input  logic                  spim_sck_i,
  input  logic                  spim_miso_i,
  input  pinmux_pkg::cs_t       spim_ssn_i,
  output pinmux_pkg::pad_vec_t  pad_out_o,
  output pinmux_pkg::pad_vec_t  pad_oen_o
);

  import pinmux_pkg::*;

  // Output-only pads, not seen by the input half
  localparam int PAD_UART0_TX  = 7;
  localparam int PAD_UART1_TX  = 10;
  localparam int PAD_PWM1_CS3  = 13;
  localparam int PAD_PWM2_CS2  = 14;
  localparam int PAD_PWM3_CS1  = 17;
  localparam int PAD_PWM4_CS0  = 18;
  localparam int PAD_SPIM_MISO = 20;
  localparam int PAD_SPIM_SCK  = 21;

  // WS281x lines span pads 5 to 20, four consecutive pads per line
  localparam int WS_PAD_LSB    = 5;
  localparam int WS_PAD_MSB    = 20;
  localparam int WS_PAD_GROUP  = 4;

  // {out, oen} for a pad turned around to input
  localparam logic [1:0] PAD_AS_INPUT = 2'b01;

  ////////////////////////////////////////////////////////////////////
  // Pad selection
  ////////////////////////////////////////////////////////////////////
  // Steps run from lowest to highest priority, last write wins
  always_comb begin
    // GPIO direction, input with 0 when clear
    for (int p = 0; p < NUM_PADS; p++) begin
      pad_out_o[p] = cfg_gpio_dir_sel_i[PAD_GPIO_BIT[p]] & pad_gpio_out_i[PAD_GPIO_BIT[p]];
      pad_oen_o[p] = ~cfg_gpio_dir_sel_i[PAD_GPIO_BIT[p]];
    end

    // WS281x type bit beats direction
    for (int p = WS_PAD_LSB; p <= WS_PAD_MSB; p++) begin
      if (cfg_gpio_out_type_i[PAD_GPIO_BIT[p]]) begin
        pad_out_o[p] = ws_txd_i[(p - WS_PAD_LSB) / WS_PAD_GROUP];
        pad_oen_o[p] = 1'b0;
      end
    end

    // Pad 6, UART0 receive
    if (uart_enb_i[0]) begin
      {pad_out_o[PAD_UART0_RX], pad_oen_o[PAD_UART0_RX]} = PAD_AS_INPUT;
    end

    // Pad 7, UART0 transmit
    if (uart_enb_i[0]) begin
      {pad_out_o[PAD_UART0_TX], pad_oen_o[PAD_UART0_TX]} = {uart_txd_i[0], 1'b0};
    end

    // Pad 8, UART1 receive or INT0
    if (uart_enb_i[1] || int_enb_i[0]) begin
      {pad_out_o[PAD_UART1_RX], pad_oen_o[PAD_UART1_RX]} = PAD_AS_INPUT;
    end

    // Pad 9, PWM0 ahead of INT1
    if (pwm_enb_i[0]) begin
      {pad_out_o[PAD_INT1], pad_oen_o[PAD_INT1]} = {pwm_wfm_i[0], 1'b0};
    end else if (int_enb_i[1]) begin
      {pad_out_o[PAD_INT1], pad_oen_o[PAD_INT1]} = PAD_AS_INPUT;
    end

    // Pad 10, UART1 transmit
    if (uart_enb_i[1]) begin
      {pad_out_o[PAD_UART1_TX], pad_oen_o[PAD_UART1_TX]} = {uart_txd_i[1], 1'b0};
    end

    // Pads 13, 14, 17, 18: PWM first, then chip select
    if (pwm_enb_i[1]) begin
      {pad_out_o[PAD_PWM1_CS3], pad_oen_o[PAD_PWM1_CS3]} = {pwm_wfm_i[1], 1'b0};
    end else if (cs_enb_i[3]) begin
      {pad_out_o[PAD_PWM1_CS3], pad_oen_o[PAD_PWM1_CS3]} = {spim_ssn_i[3], 1'b0};
    end

    if (pwm_enb_i[2]) begin
      {pad_out_o[PAD_PWM2_CS2], pad_oen_o[PAD_PWM2_CS2]} = {pwm_wfm_i[2], 1'b0};
    end else if (cs_enb_i[2]) begin
      {pad_out_o[PAD_PWM2_CS2], pad_oen_o[PAD_PWM2_CS2]} = {spim_ssn_i[2], 1'b0};
    end

    if (pwm_enb_i[3]) begin
      {pad_out_o[PAD_PWM3_CS1], pad_oen_o[PAD_PWM3_CS1]} = {pwm_wfm_i[3], 1'b0};
    end else if (cs_enb_i[1]) begin
      {pad_out_o[PAD_PWM3_CS1], pad_oen_o[PAD_PWM3_CS1]} = {spim_ssn_i[1], 1'b0};
    end

    if (pwm_enb_i[4]) begin
      {pad_out_o[PAD_PWM4_CS0], pad_oen_o[PAD_PWM4_CS0]} = {pwm_wfm_i[4], 1'b0};
    end else if (cs_enb_i[0]) begin
      {pad_out_o[PAD_PWM4_CS0], pad_oen_o[PAD_PWM4_CS0]} = {spim_ssn_i[0], 1'b0};
    end

    // Pad 19, SPI data in ahead of PWM5
    if (spim_enb_i) begin
      {pad_out_o[PAD_SPIM_MOSI], pad_oen_o[PAD_SPIM_MOSI]} = PAD_AS_INPUT;
    end else if (pwm_enb_i[5]) begin
      {pad_out_o[PAD_SPIM_MOSI], pad_oen_o[PAD_SPIM_MOSI]} = {pwm_wfm_i[5], 1'b0};
    end

    // Pads 20 and 21, SPI data out and clock
    if (spim_enb_i) begin
      {pad_out_o[PAD_SPIM_MISO], pad_oen_o[PAD_SPIM_MISO]} = {spim_miso_i, 1'b0};
      {pad_out_o[PAD_SPIM_SCK], pad_oen_o[PAD_SPIM_SCK]}   = {spim_sck_i, 1'b0};
    end

    // Strap control overrides everything on pads 13..20
    if (cfg_strap_pad_ctrl_i) begin
      pad_out_o[PAD_STRAP_LSB +: STRAP_W] = '0;
      pad_oen_o[PAD_STRAP_LSB +: STRAP_W] = '1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/pad_in_route.sv ====
// Input half of the pin multiplexer. Every pad crosses a SYNC_STAGES flop chain
// into mclk_i, so pad_in_i may be fully asynchronous. SYNC_STAGES of 2 or 3.
// The chain resets to ones, which matches pulled-up idle pads.
// Strap value is captured while strap control is high and held afterwards.
`timescale 1ns/1ps
`default_nettype none

module pad_in_route #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                  mclk_i,
  input  logic                  rst_n_i,
  input  pinmux_pkg::pad_vec_t  pad_in_i,
  input  logic                  cfg_strap_pad_ctrl_i,
  input  pinmux_pkg::uart_t     uart_enb_i,
  input  pinmux_pkg::intr_t     int_enb_i,
  input  logic                  spim_enb_i,
  output pinmux_pkg::gpio_t     pad_gpio_in_o,
  output pinmux_pkg::uart_t     uart_rxd_o,
  output pinmux_pkg::intr_t     ext_intr_o,
  output logic                  spim_mosi_o,
  output pinmux_pkg::strap_t    pad_strap_o
);

  import pinmux_pkg::*;

  // Flop chain, stage 0 samples the pads
  pad_vec_t sync_q [SYNC_STAGES];
  // Last stage, the only view of the pads used below
  pad_vec_t pad_sync;
  strap_t   strap_q;

  ////////////////////////////////////////////////////////////////////
  // Synchronizer
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge mclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int s = 0; s < SYNC_STAGES; s++) begin
        sync_q[s] <= '1;
      end
    end else begin
      sync_q[0] <= pad_in_i;
      // Shift toward the last stage
      for (int s = 1; s < SYNC_STAGES; s++) begin
        sync_q[s] <= sync_q[s-1];
      end
    end
  end

  assign pad_sync = sync_q[SYNC_STAGES-1];

  ////////////////////////////////////////////////////////////////////
  // GPIO port mapping
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    // Bits with no pad read 0
    pad_gpio_in_o = '0;
    for (int p = 0; p < NUM_PADS; p++) begin
      pad_gpio_in_o[PAD_GPIO_BIT[p]] = pad_sync[p];
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Peripheral inputs
  ////////////////////////////////////////////////////////////////////

  // UART receive idles high when not routed
  assign uart_rxd_o[0] = uart_enb_i[0] ? pad_sync[PAD_UART0_RX] : 1'b1;
  assign uart_rxd_o[1] = uart_enb_i[1] ? pad_sync[PAD_UART1_RX] : 1'b1;

  // Pad 8 is shared, UART1 receive takes it first
  always_comb begin
    ext_intr_o = '0;
    if (int_enb_i[0] && !uart_enb_i[1]) begin
      ext_intr_o[0] = pad_sync[PAD_UART1_RX];
    end
    if (int_enb_i[1]) begin
      ext_intr_o[1] = pad_sync[PAD_INT1];
    end
  end

  // SPI master data in, low when the master is off
  assign spim_mosi_o = spim_enb_i ? pad_sync[PAD_SPIM_MOSI] : 1'b0;

  ////////////////////////////////////////////////////////////////////
  // Strap capture
  ////////////////////////////////////////////////////////////////////

  // Tracks straps pads one edge behind the synchronizer
  always_ff @(posedge mclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      strap_q <= '0;
    end else if (cfg_strap_pad_ctrl_i) begin
      strap_q <= pad_sync[PAD_STRAP_LSB +: STRAP_W];
    end
  end

  assign pad_strap_o = strap_q;

  // Whole input path, sync chain through routing and strap hold, stays known
  a_in_route_known : assert property (
    @(posedge mclk_i) disable iff (!rst_n_i)
    !$isunknown({pad_gpio_in_o, uart_rxd_o, ext_intr_o, spim_mosi_o, pad_strap_o})
  );

endmodule

`default_nettype wire

// ==== hw/pinmux_pkg.sv ====
// Shared widths, pad numbers and config field positions for the pin multiplexer.
// Pad numbering follows the 28-pad package. Pads above 27 do not exist here.
// Field positions refer to the 32-bit multi-function word. Bits 31:15 are reserved.
`default_nettype none

package pinmux_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and vector types
  //////////////////////////////////////////////////////////////////////
  localparam int NUM_PADS = 28;
  typedef logic [NUM_PADS-1:0] pad_vec_t;

  // Ports A, B, C, D packed as bytes 0 to 3
  localparam int GPIO_W   = 32;
  typedef logic [GPIO_W-1:0] gpio_t;

  localparam int NUM_PWM  = 6;
  typedef logic [NUM_PWM-1:0] pwm_t;

  localparam int NUM_WS   = 4;
  typedef logic [NUM_WS-1:0] ws_t;

  localparam int NUM_UART = 2;
  typedef logic [NUM_UART-1:0] uart_t;

  localparam int NUM_INT  = 2;
  typedef logic [NUM_INT-1:0] intr_t;

  localparam int NUM_CS   = 4;
  typedef logic [NUM_CS-1:0] cs_t;

  localparam int STRAP_W  = 8;
  typedef logic [STRAP_W-1:0] strap_t;

  // Multi-function word field positions
  localparam int FN_PWM_LSB  = 0;
  localparam int FN_INT_LSB  = 6;
  localparam int FN_UART_LSB = 8;
  localparam int FN_SPIM_BIT = 10;
  localparam int FN_CS_LSB   = 11;

  // Pads shared by the input and drive halves
  localparam int PAD_STRAP_LSB = 13;
  localparam int PAD_UART0_RX  = 6;
  localparam int PAD_UART1_RX  = 8;
  localparam int PAD_INT1      = 9;
  localparam int PAD_SPIM_MOSI = 19;

  // GPIO bit behind each pad, index is the pad number
  // A5..A7 and C7 have no pad
  localparam int unsigned PAD_GPIO_BIT [NUM_PADS] = '{
    0, 1, 2, 3, 4,                          // A0..A4
    22, 24, 25, 26, 27, 28,                 // C6, D0..D4
    14, 15,                                 // B6, B7
    29, 30, 31,                             // D5..D7
    8, 9, 10, 11, 12, 13,                   // B0..B5
    16, 17, 18, 19, 20, 21                  // C0..C5
  };

endpackage

`default_nettype wire

// ==== hw/pinmux_top.sv ====
// Pin multiplexer top. Input path latency is SYNC_STAGES mclk_i edges,
// drive path is combinational. pad_oen_o is active low.
// Multi-function word bits 31:15 are reserved and ignored.
`timescale 1ns/1ps
`default_nettype none

module pinmux_top #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                  mclk_i,
  input  logic                  rst_n_i,
  input  pinmux_pkg::pad_vec_t  pad_in_i,
  output pinmux_pkg::pad_vec_t  pad_out_o,
  output pinmux_pkg::pad_vec_t  pad_oen_o,
  input  logic                  cfg_strap_pad_ctrl_i,
  input  pinmux_pkg::gpio_t     cfg_gpio_out_type_i,
  input  pinmux_pkg::gpio_t     cfg_gpio_dir_sel_i,
  input  logic [31:0]           cfg_multi_func_sel_i,
  output pinmux_pkg::pwm_t      cfg_pwm_enb_o,
  output pinmux_pkg::gpio_t     pad_gpio_in_o,
  input  pinmux_pkg::gpio_t     pad_gpio_out_i,
  input  pinmux_pkg::pwm_t      pwm_wfm_i,
  output pinmux_pkg::intr_t     ext_intr_o,
  input  pinmux_pkg::uart_t     uart_txd_i,
  output pinmux_pkg::uart_t     uart_rxd_o,
  input  logic                  spim_sck_i,
  input  pinmux_pkg::cs_t       spim_ssn_i,
  input  logic                  spim_miso_i,
  output logic                  spim_mosi_o,
  input  pinmux_pkg::ws_t       ws_txd_i,
  output pinmux_pkg::strap_t    pad_strap_o
);

  import pinmux_pkg::*;

  // Enables sliced from the multi-function word
  pwm_t  pwm_enb;
  intr_t int_enb;
  uart_t uart_enb;
  logic  spim_enb;
  cs_t   cs_enb;

  assign pwm_enb  = cfg_multi_func_sel_i[FN_PWM_LSB +: NUM_PWM];
  assign int_enb  = cfg_multi_func_sel_i[FN_INT_LSB +: NUM_INT];
  assign uart_enb = cfg_multi_func_sel_i[FN_UART_LSB +: NUM_UART];
  assign spim_enb = cfg_multi_func_sel_i[FN_SPIM_BIT];
  assign cs_enb   = cfg_multi_func_sel_i[FN_CS_LSB +: NUM_CS];

  // PWM block needs its own enables back
  assign cfg_pwm_enb_o = pwm_enb;

  pad_in_route #(
    .SYNC_STAGES          (SYNC_STAGES)
  ) u_in_route (
    .mclk_i               (mclk_i),
    .rst_n_i              (rst_n_i),
    .pad_in_i             (pad_in_i),
    .cfg_strap_pad_ctrl_i (cfg_strap_pad_ctrl_i),
    .uart_enb_i           (uart_enb),
    .int_enb_i            (int_enb),
    .spim_enb_i           (spim_enb),
    .pad_gpio_in_o        (pad_gpio_in_o),
    .uart_rxd_o           (uart_rxd_o),
    .ext_intr_o           (ext_intr_o),
    .spim_mosi_o          (spim_mosi_o),
    .pad_strap_o          (pad_strap_o)
  );

  pad_drive_sel u_drive_sel (
    .cfg_strap_pad_ctrl_i (cfg_strap_pad_ctrl_i),
    .cfg_gpio_dir_sel_i   (cfg_gpio_dir_sel_i),
    .cfg_gpio_out_type_i  (cfg_gpio_out_type_i),
    .pwm_enb_i            (pwm_enb),
    .int_enb_i            (int_enb),
    .uart_enb_i           (uart_enb),
    .spim_enb_i           (spim_enb),
    .cs_enb_i             (cs_enb),
    .pad_gpio_out_i       (pad_gpio_out_i),
    .pwm_wfm_i            (pwm_wfm_i),
    .ws_txd_i             (ws_txd_i),
    .uart_txd_i           (uart_txd_i),
    .spim_sck_i           (spim_sck_i),
    .spim_miso_i          (spim_miso_i),
    .spim_ssn_i           (spim_ssn_i),
    .pad_out_o            (pad_out_o),
    .pad_oen_o            (pad_oen_o)
  );

  ////////////////////////////////////////////////////////////////////
  // Drive checks
  ////////////////////////////////////////////////////////////////////
  // Strap capture in the input half relies on these pads floating
  a_strap_not_driven : assert property (
    @(posedge mclk_i) disable iff (!rst_n_i)
    cfg_strap_pad_ctrl_i |-> &pad_oen_o[PAD_STRAP_LSB +: STRAP_W]
  );

  // Undriven pads never carry a stale value
  a_idle_pad_low : assert property (
    @(posedge mclk_i) disable iff (!rst_n_i)
    (pad_out_o & pad_oen_o) == '0
  );

endmodule

`default_nettype wire

// ==== include/tb_pinmux_checks.svh ====
// Compare tasks and random source for the pin multiplexer testbench.
// Included in the testbench module body after the pinmux_pkg import and
// after the failure task. Mismatches print in hex and end the run.
`ifndef TB_PINMUX_CHECKS_SVH
`define TB_PINMUX_CHECKS_SVH

  // Random state, fixed seed
  logic [31:0] rng_state = 32'hf3a9;

  // xorshift32 with the 13/17/5 shift triple
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Typed compares, one per result kind
  //////////////////////////////////////////////////////////////////////
  task automatic pad_vec_cmp(input string name, input pad_vec_t got, input pad_vec_t want);
    if (got !== want) begin
      fail_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, want));
    end
  endtask

  task automatic gpio_cmp(input string name, input gpio_t got, input gpio_t want);
    if (got !== want) begin
      fail_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, want));
    end
  endtask

  task automatic pwm_cmp(input string name, input pwm_t got, input pwm_t want);
    if (got !== want) begin
      fail_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, want));
    end
  endtask

  task automatic uart_cmp(input string name, input uart_t got, input uart_t want);
    if (got !== want) begin
      fail_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, want));
    end
  endtask

  task automatic intr_cmp(input string name, input intr_t got, input intr_t want);
    if (got !== want) begin
      fail_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, want));
    end
  endtask

  task automatic strap_cmp(input string name, input strap_t got, input strap_t want);
    if (got !== want) begin
      fail_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, want));
    end
  endtask

  // Single-bit outputs such as SPI data in
  task automatic bit_cmp(input string name, input logic got, input logic want);
    if (got !== want) begin
      fail_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, want));
    end
  endtask

`endif

// ==== verif/tb_pinmux.sv ====
// Directed tests for pinmux_top with SYNC_STAGES of 2.
// Inputs change 1 ns after a rising edge, drive outputs are sampled 1 ns later.
// Expected values follow the pad table and drive rule.
`timescale 1ns/1ps
`default_nettype none

module tb_pinmux;

  import pinmux_pkg::*;

  localparam int SYNC_STAGES = 2;
  // Tests need about 300 cycles
  localparam int MAX_CYCLES  = 2000;

  logic        clk        = 1'b0;
  logic        rst_n      = 1'b0;
  pad_vec_t    pad_in     = '1;
  logic        strap_ctrl = 1'b0;
  gpio_t       gpio_type  = '0;
  gpio_t       gpio_dir   = '0;
  gpio_t       gpio_out   = '0;
  logic [31:0] mfs        = '0;
  pwm_t        pwm_wfm    = '0;
  uart_t       uart_txd   = '0;
  logic        spim_sck   = 1'b0;
  logic        spim_miso  = 1'b0;
  cs_t         spim_ssn   = '0;
  ws_t         ws_txd     = '0;
  int          cycles     = 0;
  pad_vec_t    pad_out;
  pad_vec_t    pad_oen;
  pwm_t        pwm_enb;
  gpio_t       gpio_in;
  intr_t       ext_intr;
  uart_t       uart_rxd;
  logic        spim_mosi;
  strap_t      strap;

  pinmux_top #(
    .SYNC_STAGES          (SYNC_STAGES)
  ) uut (
    .mclk_i               (clk),
    .rst_n_i              (rst_n),
    .pad_in_i             (pad_in),
    .pad_out_o            (pad_out),
    .pad_oen_o            (pad_oen),
    .cfg_strap_pad_ctrl_i (strap_ctrl),
    .cfg_gpio_out_type_i  (gpio_type),
    .cfg_gpio_dir_sel_i   (gpio_dir),
    .cfg_multi_func_sel_i (mfs),
    .cfg_pwm_enb_o        (pwm_enb),
    .pad_gpio_in_o        (gpio_in),
    .pad_gpio_out_i       (gpio_out),
    .pwm_wfm_i            (pwm_wfm),
    .ext_intr_o           (ext_intr),
    .uart_txd_i           (uart_txd),
    .uart_rxd_o           (uart_rxd),
    .spim_sck_i           (spim_sck),
    .spim_ssn_i           (spim_ssn),
    .spim_miso_i          (spim_miso),
    .spim_mosi_o          (spim_mosi),
    .ws_txd_i             (ws_txd),
    .pad_strap_o          (strap)
  );

  always #2 clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  `include "tb_pinmux_checks.svh"

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      fail_run("Run did not finish within the cycle limit");
    end
  end

  task automatic next_edge();
    @(posedge clk);
    #1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////
  // GPIO bit behind each pad, per pad table
  function automatic int gpio_bit_of(input int p);
    if (p <= 4) return p;
    if (p == 5) return 22;
    if (p <= 10) return p + 18;
    if (p <= 12) return p + 3;
    if (p <= 15) return p + 16;
    if (p <= 21) return p - 8;
    return p - 6;
  endfunction

  function automatic gpio_t gpio_from_pads(input pad_vec_t pads);
    gpio_t g;
    g = '0;
    for (int p = 0; p < NUM_PADS; p++) begin
      g[gpio_bit_of(p)] = pads[p];
    end
    return g;
  endfunction

  // {out, oen} of one pad, first matching step wins
  function automatic logic [1:0] pad_rule(input int p);
    int g;
    int pw;
    g  = gpio_bit_of(p);
    pw = (p < 15) ? p - 12 : p - 14;
    if (strap_ctrl && p >= PAD_STRAP_LSB && p < PAD_STRAP_LSB + STRAP_W) return 2'b01;
    case (p)
      6: if (mfs[FN_UART_LSB]) return 2'b01;
      7: if (mfs[FN_UART_LSB]) return {uart_txd[0], 1'b0};
      8: if (mfs[FN_UART_LSB+1] || mfs[FN_INT_LSB]) return 2'b01;
      9: begin
        if (mfs[FN_PWM_LSB]) return {pwm_wfm[0], 1'b0};
        if (mfs[FN_INT_LSB+1]) return 2'b01;
      end
      10: if (mfs[FN_UART_LSB+1]) return {uart_txd[1], 1'b0};
      // PWM1..4 then CS3..0
      13, 14, 17, 18: begin
        if (mfs[FN_PWM_LSB+pw]) return {pwm_wfm[pw], 1'b0};
        if (mfs[FN_CS_LSB+4-pw]) return {spim_ssn[4-pw], 1'b0};
      end
      19: begin
        if (mfs[FN_SPIM_BIT]) return 2'b01;
        if (mfs[FN_PWM_LSB+5]) return {pwm_wfm[5], 1'b0};
      end
      20: if (mfs[FN_SPIM_BIT]) return {spim_miso, 1'b0};
      21: if (mfs[FN_SPIM_BIT]) return {spim_sck, 1'b0};
      default: ;
    endcase
    if (p >= 5 && p <= 20 && gpio_type[g]) return {ws_txd[(p - 5) / 4], 1'b0};
    if (gpio_dir[g]) return {gpio_out[g], 1'b0};
    return 2'b01;
  endfunction

  task automatic check_drive();
    pad_vec_t exp_out;
    pad_vec_t exp_oen;
    #1;
    for (int p = 0; p < NUM_PADS; p++) begin
      {exp_out[p], exp_oen[p]} = pad_rule(p);
    end
    pad_vec_cmp("pad_out_o", pad_out, exp_out);
    pad_vec_cmp("pad_oen_o", pad_oen, exp_oen);
    // PWM field is the low six bits of the word
    pwm_cmp("cfg_pwm_enb_o", pwm_enb, pwm_t'(mfs >> FN_PWM_LSB));
  endtask

  // Input side for settled pad values
  task automatic check_routed(input pad_vec_t pads);
    uart_t exp_rxd;
    intr_t exp_intr;
    exp_rxd[0]  = mfs[FN_UART_LSB] ? pads[PAD_UART0_RX] : 1'b1;
    exp_rxd[1]  = mfs[FN_UART_LSB+1] ? pads[PAD_UART1_RX] : 1'b1;
    // UART1 receive owns pad 8 before INT0
    exp_intr[0] = (mfs[FN_INT_LSB] && !mfs[FN_UART_LSB+1]) ? pads[PAD_UART1_RX] : 1'b0;
    exp_intr[1] = mfs[FN_INT_LSB+1] ? pads[PAD_INT1] : 1'b0;
    uart_cmp("uart_rxd_o", uart_rxd, exp_rxd);
    intr_cmp("ext_intr_o", ext_intr, exp_intr);
    bit_cmp("spim_mosi_o", spim_mosi, mfs[FN_SPIM_BIT] & pads[PAD_SPIM_MOSI]);
    gpio_cmp("pad_gpio_in_o", gpio_in, gpio_from_pads(pads));
  endtask

  // Old value up to edge SYNC_STAGES-1, new value from edge SYNC_STAGES
  task automatic apply_pads(input pad_vec_t pads);
    pad_vec_t old;
    next_edge();
    old    = pad_in;
    pad_in = pads;
    repeat (SYNC_STAGES - 1) next_edge();
    check_routed(old);
    next_edge();
    check_routed(pads);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////
  task automatic reset_defaults();
    check_drive();
    check_routed(pad_in);
    strap_cmp("pad_strap_o", strap, '0);
  endtask

  task automatic gpio_random();
    for (int i = 0; i < 20; i++) begin
      next_edge();
      gpio_dir  = next_random();
      gpio_type = next_random();
      gpio_out  = next_random();
      ws_txd    = ws_t'(next_random());
      check_drive();
      apply_pads(pad_vec_t'(next_random()));
    end
  endtask

  // Pads 13, 14, 17, 18 with every source on, then stripped
  task automatic output_priority();
    gpio_t sel;
    // D5, D6, B1, B2
    sel = 32'h6000_0600;
    for (int r = 0; r < 4; r++) begin
      next_edge();
      pwm_wfm   = pwm_t'(next_random());
      spim_ssn  = cs_t'(next_random());
      ws_txd    = ws_t'(next_random());
      gpio_out  = next_random();
      gpio_type = sel;
      gpio_dir  = sel;
      // PWM1..4 and CS0..3
      mfs       = 32'h0000_781e;
      check_drive();
      next_edge();
      mfs = 32'h0000_7800;
      check_drive();
      next_edge();
      mfs = '0;
      check_drive();
      next_edge();
      gpio_type = '0;
      check_drive();
      next_edge();
      gpio_dir = '0;
      check_drive();
    end
  endtask

  task automatic input_routing();
    logic [31:0] r;
    for (int c = 0; c < 3; c++) begin
      next_edge();
      // Every pad wants to drive, functions must turn 6, 8, 9, 19 around
      gpio_dir  = '1;
      r         = next_random();
      uart_txd  = r[1:0];
      spim_sck  = r[2];
      spim_miso = r[3];
      case (c)
        0:       mfs = 32'h0000_07c0;
        1:       mfs = 32'h0000_05c0;
        // Inputs off, PWM0 and PWM5 take pads 9 and 19
        default: mfs = 32'h0000_0021;
      endcase
      check_drive();
      // Transmit, clock and PWM sources at the other level
      uart_txd  = ~uart_txd;
      spim_sck  = ~spim_sck;
      spim_miso = ~spim_miso;
      pwm_wfm   = ~pwm_wfm;
      check_drive();
      for (int i = 0; i < 6; i++) begin
        apply_pads(pad_vec_t'(next_random()));
      end
    end
  endtask

  task automatic strap_capture();
    strap_t held;
    next_edge();
    strap_ctrl = 1'b1;
    gpio_dir   = '1;
    gpio_type  = '1;
    mfs        = 32'h0000_7fff;
    check_drive();
    for (int i = 0; i < 6; i++) begin
      next_edge();
      held   = strap;
      pad_in = pad_vec_t'(next_random());
      repeat (SYNC_STAGES) next_edge();
      strap_cmp("pad_strap_o", strap, held);
      next_edge();
      strap_cmp("pad_strap_o", strap, pad_in[PAD_STRAP_LSB +: STRAP_W]);
    end
    // Strap control off, register holds
    next_edge();
    held       = strap;
    strap_ctrl = 1'b0;
    check_drive();
    for (int i = 0; i < 4; i++) begin
      apply_pads(pad_vec_t'(next_random()));
      next_edge();
      strap_cmp("pad_strap_o", strap, held);
    end
  endtask

  initial begin
    repeat (3) next_edge();
    rst_n = 1'b1;
    reset_defaults();
    gpio_random();
    output_priority();
    input_routing();
    strap_capture();
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
hw/pinmux_pkg.sv
hw/pad_in_route.sv
hw/pad_drive_sel.sv
hw/pinmux_top.sv
verif/tb_pinmux.sv
